// File: common/ps_defs.svh
`ifndef PS_DEFS_SVH
`define PS_DEFS_SVH

// bus widths
`define PS_ADDR_W 32
`define PS_DATA_W 32

// gpio pins
`define GPIO_W 24

// spi clock divider, half period is div+1 cycles
`define SPI_DIV_W   8
`define SPI_DIV_RST 3

// register map, byte offsets
`define REG_GPIO_OUT 32'h0000_0000
`define REG_GPIO_DIR 32'h0000_0004
`define REG_GPIO_IN  32'h0000_0008
`define REG_SPI_TX   32'h0000_0010
`define REG_SPI_STAT 32'h0000_0014
`define REG_SPI_RX   32'h0000_0018
`define REG_SPI_DIV  32'h0000_001C

`endif

// File: common/ps_pkg.sv
package ps_pkg;

  //////////////////////////////////////////////////////////////////////
  // host command
  //////////////////////////////////////////////////////////////////////

  // single access, read or write
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } gp_op_e;

  // response codes as on the AXI B and R channels
  // exokay and decerr never produced here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } gp_resp_e;

  //////////////////////////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////////////////////////

  // bus master, one transfer in flight at most
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRITE = 2'd1,
    ST_READ  = 2'd2
  } gp_state_e;

  // spi engine, low and high half of each sck period
  typedef enum logic [1:0] {
    SPI_IDLE = 2'd0,
    SPI_LOW  = 2'd1,
    SPI_HIGH = 2'd2
  } spi_state_e;

endpackage : ps_pkg

// File: ps_system.f
+incdir+common
common/ps_pkg.sv
spi/spi_master.sv
rtl/gp_master.sv
rtl/gp_regs.sv
rtl/ps_system.sv
test/tb_ps_system.sv

// File: rtl/gp_master.sv
`timescale 1ns/1ns
`include "ps_defs.svh"

module gp_master import ps_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // host command port
  input  logic                  cmd_valid_i,
  input  gp_op_e                cmd_op_i,
  input  logic [`PS_ADDR_W-1:0] cmd_addr_i,
  input  logic [`PS_DATA_W-1:0] cmd_wdata_i,
  output logic                  cmd_busy_o,
  output logic                  cmd_done_o,
  output gp_resp_e              cmd_resp_o,
  output logic [`PS_DATA_W-1:0] cmd_rdata_o,
  // write address, write data, write response
  output logic                  awvalid_o,
  output logic [`PS_ADDR_W-1:0] awaddr_o,
  input  logic                  awready_i,
  output logic                  wvalid_o,
  output logic [`PS_DATA_W-1:0] wdata_o,
  input  logic                  wready_i,
  input  logic                  bvalid_i,
  input  gp_resp_e              bresp_i,
  output logic                  bready_o,
  // read address, read data
  output logic                  arvalid_o,
  output logic [`PS_ADDR_W-1:0] araddr_o,
  input  logic                  arready_i,
  input  logic                  rvalid_i,
  input  logic [`PS_DATA_W-1:0] rdata_i,
  input  gp_resp_e              rresp_i,
  output logic                  rready_o
);

  gp_state_e state;
  logic      cmd_take;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  logic      ar_fire;
  logic      r_fire;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  assign cmd_take = (state == ST_IDLE) && cmd_valid_i;

  // beat moves when valid and ready meet
  assign aw_fire = awvalid_o && awready_i;
  assign w_fire  = wvalid_o && wready_i;
  assign b_fire  = bvalid_i && bready_o;
  assign ar_fire = arvalid_o && arready_i;
  assign r_fire  = rvalid_i && rready_o;

  // response channels always open while waiting
  assign bready_o = (state == ST_WRITE);
  assign rready_o = (state == ST_READ);

  // low again in the done cycle
  assign cmd_busy_o = (state != ST_IDLE);

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state      <= ST_IDLE;
      awvalid_o  <= 1'b0;
      wvalid_o   <= 1'b0;
      arvalid_o  <= 1'b0;
      cmd_done_o <= 1'b0;
    end else begin
      cmd_done_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_valid_i) begin
            if (cmd_op_i == OP_WRITE) begin
              // address and data go out together
              state     <= ST_WRITE;
              awvalid_o <= 1'b1;
              wvalid_o  <= 1'b1;
            end else begin
              state     <= ST_READ;
              arvalid_o <= 1'b1;
            end
          end
        end
        ST_WRITE: begin
          // aw and w may be taken in either order
          if (aw_fire) begin
            awvalid_o <= 1'b0;
          end
          if (w_fire) begin
            wvalid_o <= 1'b0;
          end
          if (b_fire) begin
            state      <= ST_IDLE;
            cmd_done_o <= 1'b1;
          end
        end
        ST_READ: begin
          if (ar_fire) begin
            arvalid_o <= 1'b0;
          end
          if (r_fire) begin
            state      <= ST_IDLE;
            cmd_done_o <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload and result
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // command fields held stable until accepted
    if (cmd_take) begin
      awaddr_o <= cmd_addr_i;
      araddr_o <= cmd_addr_i;
      wdata_o  <= cmd_wdata_i;
    end
    // result kept until the next done
    if (b_fire) begin
      cmd_resp_o  <= bresp_i;
      cmd_rdata_o <= '0;
    end
    if (r_fire) begin
      cmd_resp_o  <= rresp_i;
      cmd_rdata_o <= rdata_i;
    end
  end

  // host only issues while idle
  assert property (@(posedge clk) disable iff (!arst_n_i) cmd_valid_i |-> !cmd_busy_o);

endmodule : gp_master

// File: rtl/gp_regs.sv
`timescale 1ns/1ns
`include "ps_defs.svh"

module gp_regs import ps_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // write address, write data, write response
  input  logic                  awvalid_i,
  input  logic [`PS_ADDR_W-1:0] awaddr_i,
  output logic                  awready_o,
  input  logic                  wvalid_i,
  input  logic [`PS_DATA_W-1:0] wdata_i,
  output logic                  wready_o,
  output logic                  bvalid_o,
  output gp_resp_e              bresp_o,
  input  logic                  bready_i,
  // read address, read data
  input  logic                  arvalid_i,
  input  logic [`PS_ADDR_W-1:0] araddr_i,
  output logic                  arready_o,
  output logic                  rvalid_o,
  output logic [`PS_DATA_W-1:0] rdata_o,
  output gp_resp_e              rresp_o,
  input  logic                  rready_i,
  // gpio pins
  input  logic [`GPIO_W-1:0]    gpio_i,
  output logic [`GPIO_W-1:0]    gpio_o,
  output logic [`GPIO_W-1:0]    gpio_t_o,
  // spi engine
  output logic                  spi_start_o,
  output logic [7:0]            spi_tx_o,
  output logic [`SPI_DIV_W-1:0] spi_div_o,
  input  logic                  spi_busy_i,
  input  logic [7:0]            spi_rx_i
);

  logic [`GPIO_W-1:0]    gpio_out;
  logic [`GPIO_W-1:0]    gpio_dir;
  logic [`GPIO_W-1:0]    gpio_in_q;
  logic                  spi_active;
  logic                  wr_fire;
  logic                  rd_fire;
  logic                  tx_take;
  gp_resp_e              wr_resp;
  gp_resp_e              rd_resp;
  logic [`PS_DATA_W-1:0] rd_data;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  // aw and w taken in the same cycle, only with no B waiting
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  // one read response outstanding at most
  assign arready_o = !rvalid_o;
  assign rd_fire   = arvalid_i && arready_o;

  // start pulse counts as busy, engine flag follows one cycle later
  assign spi_active = spi_busy_i || spi_start_o;
  assign tx_take    = wr_fire && (awaddr_i == `REG_SPI_TX) && !spi_active;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (awaddr_i)
      // tx write while busy dropped, still okay
      `REG_GPIO_OUT, `REG_GPIO_DIR, `REG_SPI_TX, `REG_SPI_DIV: wr_resp = RESP_OKAY;
      // read-only or unmapped
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_resp = RESP_OKAY;
    rd_data = '0;
    case (araddr_i)
      `REG_GPIO_OUT: rd_data = {{(`PS_DATA_W-`GPIO_W){1'b0}}, gpio_out};
      `REG_GPIO_DIR: rd_data = {{(`PS_DATA_W-`GPIO_W){1'b0}}, gpio_dir};
      `REG_GPIO_IN:  rd_data = {{(`PS_DATA_W-`GPIO_W){1'b0}}, gpio_in_q};
      `REG_SPI_STAT: rd_data = {{(`PS_DATA_W-1){1'b0}}, spi_active};
      `REG_SPI_RX:   rd_data = {{(`PS_DATA_W-8){1'b0}}, spi_rx_i};
      `REG_SPI_DIV:  rd_data = {{(`PS_DATA_W-`SPI_DIV_W){1'b0}}, spi_div_o};
      // tx is write-only, falls through to error with zero data
      default:       rd_resp = RESP_SLVERR;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out    <= '0;
      gpio_dir    <= '0;
      spi_div_o   <= `SPI_DIV_W'(`SPI_DIV_RST);
      spi_start_o <= 1'b0;
      bvalid_o    <= 1'b0;
      rvalid_o    <= 1'b0;
    end else begin
      spi_start_o <= tx_take;
      if (wr_fire) begin
        case (awaddr_i)
          `REG_GPIO_OUT: gpio_out  <= wdata_i[`GPIO_W-1:0];
          `REG_GPIO_DIR: gpio_dir  <= wdata_i[`GPIO_W-1:0];
          `REG_SPI_DIV:  spi_div_o <= wdata_i[`SPI_DIV_W-1:0];
          default: ;
        endcase
      end
      // B and R held until the master takes them
      if (wr_fire) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    // pins sampled one cycle back
    gpio_in_q <= gpio_i;
    if (tx_take) begin
      spi_tx_o <= wdata_i[7:0];
    end
    if (wr_fire) begin
      bresp_o <= wr_resp;
    end
    if (rd_fire) begin
      rdata_o <= rd_data;
      rresp_o <= rd_resp;
    end
  end

  // dir bit set drives the pin
  assign gpio_o   = gpio_out;
  assign gpio_t_o = ~gpio_dir;

  // responses wait for the master without change
  assert property (@(posedge clk) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));
  assert property (@(posedge clk) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule : gp_regs

// File: rtl/ps_system.sv
`timescale 1ns/1ns
`include "ps_defs.svh"

module ps_system import ps_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // host command port
  input  logic                  cmd_valid_i,
  input  gp_op_e                cmd_op_i,
  input  logic [`PS_ADDR_W-1:0] cmd_addr_i,
  input  logic [`PS_DATA_W-1:0] cmd_wdata_i,
  output logic                  cmd_busy_o,
  output logic                  cmd_done_o,
  output gp_resp_e              cmd_resp_o,
  output logic [`PS_DATA_W-1:0] cmd_rdata_o,
  // gpio
  input  logic [`GPIO_W-1:0]    gpio_i,
  output logic [`GPIO_W-1:0]    gpio_o,
  output logic [`GPIO_W-1:0]    gpio_t_o,
  // spi
  output logic                  spi_sck_o,
  output logic                  spi_mosi_o,
  input  logic                  spi_miso_i,
  output logic                  spi_ss_n_o
);

  //////////////////////////////////////////////////////////////////////
  // gp bus
  //////////////////////////////////////////////////////////////////////

  logic                  awvalid;
  logic [`PS_ADDR_W-1:0] awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [`PS_DATA_W-1:0] wdata;
  logic                  wready;
  logic                  bvalid;
  gp_resp_e              bresp;
  logic                  bready;
  logic                  arvalid;
  logic [`PS_ADDR_W-1:0] araddr;
  logic                  arready;
  logic                  rvalid;
  logic [`PS_DATA_W-1:0] rdata;
  gp_resp_e              rresp;
  logic                  rready;

  // register block to spi engine
  logic                  spi_start;
  logic [7:0]            spi_tx;
  logic [`SPI_DIV_W-1:0] spi_div;
  logic                  spi_busy;
  logic [7:0]            spi_rx;

  gp_master u_gp_master (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_busy_o  (cmd_busy_o),
    .cmd_done_o  (cmd_done_o),
    .cmd_resp_o  (cmd_resp_o),
    .cmd_rdata_o (cmd_rdata_o),
    .awvalid_o   (awvalid),
    .awaddr_o    (awaddr),
    .awready_i   (awready),
    .wvalid_o    (wvalid),
    .wdata_o     (wdata),
    .wready_i    (wready),
    .bvalid_i    (bvalid),
    .bresp_i     (bresp),
    .bready_o    (bready),
    .arvalid_o   (arvalid),
    .araddr_o    (araddr),
    .arready_i   (arready),
    .rvalid_i    (rvalid),
    .rdata_i     (rdata),
    .rresp_i     (rresp),
    .rready_o    (rready)
  );

  gp_regs u_gp_regs (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .awvalid_i   (awvalid),
    .awaddr_i    (awaddr),
    .awready_o   (awready),
    .wvalid_i    (wvalid),
    .wdata_i     (wdata),
    .wready_o    (wready),
    .bvalid_o    (bvalid),
    .bresp_o     (bresp),
    .bready_i    (bready),
    .arvalid_i   (arvalid),
    .araddr_i    (araddr),
    .arready_o   (arready),
    .rvalid_o    (rvalid),
    .rdata_o     (rdata),
    .rresp_o     (rresp),
    .rready_i    (rready),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_t_o    (gpio_t_o),
    .spi_start_o (spi_start),
    .spi_tx_o    (spi_tx),
    .spi_div_o   (spi_div),
    .spi_busy_i  (spi_busy),
    .spi_rx_i    (spi_rx)
  );

  //////////////////////////////////////////////////////////////////////
  // spi
  //////////////////////////////////////////////////////////////////////

  spi_master u_spi_master (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (spi_start),
    .tx_i     (spi_tx),
    .div_i    (spi_div),
    .busy_o   (spi_busy),
    .rx_o     (spi_rx),
    .sck_o    (spi_sck_o),
    .mosi_o   (spi_mosi_o),
    .miso_i   (spi_miso_i),
    .ss_n_o   (spi_ss_n_o)
  );

endmodule : ps_system

// File: spi/spi_master.sv
`timescale 1ns/1ns
`include "ps_defs.svh"

module spi_master import ps_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // control from the register block
  input  logic                  start_i,
  input  logic [7:0]            tx_i,
  input  logic [`SPI_DIV_W-1:0] div_i,
  output logic                  busy_o,
  output logic [7:0]            rx_o,
  // spi pins, mode 0
  output logic                  sck_o,
  output logic                  mosi_o,
  input  logic                  miso_i,
  output logic                  ss_n_o
);

  spi_state_e            state;
  logic [`SPI_DIV_W-1:0] div_q;
  logic [`SPI_DIV_W-1:0] cnt;
  logic [2:0]            bit_cnt;
  logic [7:0]            shreg;
  logic                  miso_q;
  logic                  phase_end;

  // each sck half lasts div+1 cycles
  assign phase_end = (cnt == div_q);

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state   <= SPI_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      ss_n_o  <= 1'b1;
      rx_o    <= '0;
    end else begin
      case (state)
        SPI_IDLE: begin
          if (start_i) begin
            state   <= SPI_LOW;
            cnt     <= '0;
            bit_cnt <= '0;
            ss_n_o  <= 1'b0;
          end
        end
        SPI_LOW: begin
          if (phase_end) begin
            cnt   <= '0;
            state <= SPI_HIGH;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        SPI_HIGH: begin
          if (phase_end) begin
            cnt <= '0;
            if (bit_cnt == 3'd7) begin
              // last bit, release the slave
              state  <= SPI_IDLE;
              ss_n_o <= 1'b1;
              rx_o   <= {shreg[6:0], miso_q};
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              state   <= SPI_LOW;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state  <= SPI_IDLE;
          ss_n_o <= 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == SPI_IDLE && start_i) begin
      // divider frozen for the whole byte
      shreg <= tx_i;
      div_q <= div_i;
    end
    // sample on rising sck
    if (state == SPI_LOW && phase_end) begin
      miso_q <= miso_i;
    end
    // shift on falling sck, msb first
    if (state == SPI_HIGH && phase_end) begin
      shreg <= {shreg[6:0], miso_q};
    end
  end

  assign busy_o = (state != SPI_IDLE);
  assign sck_o  = (state == SPI_HIGH);
  // mosi parked low between transfers
  assign mosi_o = busy_o && shreg[7];

  // select tracks the transfer window
  assert property (@(posedge clk) disable iff (!arst_n_i) ss_n_o == !busy_o);

endmodule : spi_master

// File: test/ps_system_cases.txt
# name op addr wdata resp rdata, hex fields
# op W write, R read, P poll until idle; rdata X is gpio_i, - is not checked
rst_out_rd      R 00000000 00000000 OKAY   00000000
rst_dir_rd      R 00000004 00000000 OKAY   00000000
rst_stat_rd     R 00000014 00000000 OKAY   00000000
rst_div_rd      R 0000001C 00000000 OKAY   00000003
out_wr          W 00000000 A5C3F00F OKAY   -
dir_wr          W 00000004 FF0F00F0 OKAY   -
out_rd          R 00000000 00000000 OKAY   00C3F00F
dir_rd          R 00000004 00000000 OKAY   000F00F0
gpio_in_rd      R 00000008 00000000 OKAY   X
div0_wr         W 0000001C 00000000 OKAY   -
div0_rd         R 0000001C 00000000 OKAY   00000000
tx0_wr          W 00000010 000000A6 OKAY   -
tx0_poll        P 00000014 00000000 OKAY   00000000
rx0_rd          R 00000018 00000000 OKAY   000000A6
div5_wr         W 0000001C 00000005 OKAY   -
tx5_wr          W 00000010 0000003C OKAY   -
tx5_busy_wr     W 00000010 000000FF OKAY   -
stat_busy_rd    R 00000014 00000000 OKAY   00000001
tx5_poll        P 00000014 00000000 OKAY   00000000
rx5_rd          R 00000018 00000000 OKAY   0000003C
unmapped_rd     R 00000040 00000000 SLVERR 00000000
gpio_in_wr      W 00000008 12345678 SLVERR -
gpio_in_rd2     R 00000008 00000000 OKAY   X
spi_rx_wr       W 00000018 000000FF SLVERR -
spi_rx_rd2      R 00000018 00000000 OKAY   0000003C
out_wr2         W 00000000 0000FF00 OKAY   -
out_rd2         R 00000000 00000000 OKAY   0000FF00

// File: test/tb_ps_system.sv
`timescale 1ns/1ns
`include "ps_defs.svh"

module tb_ps_system import ps_pkg::*; ();

  // worst case spi byte at the largest divider plus bus overhead
  localparam int CASE_CYCLES = 16 * 256 + 20;

  logic                  clk = 1'b0;
  logic                  arst_n_i;
  logic                  cmd_valid_i;
  gp_op_e                cmd_op_i;
  logic [`PS_ADDR_W-1:0] cmd_addr_i;
  logic [`PS_DATA_W-1:0] cmd_wdata_i;
  logic                  cmd_busy_o;
  logic                  cmd_done_o;
  gp_resp_e              cmd_resp_o;
  logic [`PS_DATA_W-1:0] cmd_rdata_o;
  logic [`GPIO_W-1:0]    gpio_i;
  logic [`GPIO_W-1:0]    gpio_o;
  logic [`GPIO_W-1:0]    gpio_t_o;
  logic                  spi_sck_o;
  logic                  spi_mosi_o;
  logic                  spi_ss_n_o;

  // case table with one entry per line of the cases file
  string                 case_name[$];
  string                 case_op[$];
  logic [`PS_ADDR_W-1:0] case_addr[$];
  logic [`PS_DATA_W-1:0] case_wdata[$];
  string                 case_resp[$];
  string                 case_data[$];

  integer                seed = 32'hdafc7073;
  logic [`GPIO_W-1:0]    gpio_pat;
  // pin model following the OUT and DIR writes
  logic [`GPIO_W-1:0]    exp_out;
  logic [`GPIO_W-1:0]    exp_dir;
  int unsigned           cycles = 0;
  int unsigned           cycle_limit = 0;
  // sck rising edges seen since time zero
  logic                  sck_q = 1'b0;
  int unsigned           sck_rises = 0;

  always #4 clk = ~clk;

  // mosi looped straight back into miso
  ps_system UUT (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_busy_o  (cmd_busy_o),
    .cmd_done_o  (cmd_done_o),
    .cmd_resp_o  (cmd_resp_o),
    .cmd_rdata_o (cmd_rdata_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_t_o    (gpio_t_o),
    .spi_sck_o   (spi_sck_o),
    .spi_mosi_o  (spi_mosi_o),
    .spi_miso_i  (spi_mosi_o),
    .spi_ss_n_o  (spi_ss_n_o)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_resp(input string name, input gp_resp_e exp, input gp_resp_e act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected resp %0d, actual resp %0d", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input logic [`PS_DATA_W-1:0] exp,
                            input logic [`PS_DATA_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected data %h, actual data %h", name, exp, act));
    end
  endtask

  task automatic check_gpio(input string name, input logic [`GPIO_W-1:0] exp,
                            input logic [`GPIO_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected pins %h, actual pins %h", name, exp, act));
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected level %b, actual level %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    if (act != exp) begin
      abort_run($sformatf("[ERROR] %s: expected count %0d, actual count %0d", name, exp, act));
    end
  endtask

  // '#' lines and blank lines skipped
  task automatic load_cases();
    int                    fd;
    int                    cnt;
    string                 line;
    string                 name;
    string                 op;
    string                 resp;
    string                 data;
    logic [`PS_ADDR_W-1:0] addr;
    logic [`PS_DATA_W-1:0] wdata;
    fd = $fopen("test/ps_system_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the case file test/ps_system_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
        cnt = $sscanf(line, "%s %s %h %h %s %s", name, op, addr, wdata, resp, data);
        if (cnt == 6) begin
          case_name.push_back(name);
          case_op.push_back(op);
          case_addr.push_back(addr);
          case_wdata.push_back(wdata);
          case_resp.push_back(resp);
          case_data.push_back(data);
        end else if (cnt > 0) begin
          abort_run({"malformed line in the case file: ", line});
        end
      end
    end
    $fclose(fd);
  endtask

  // one command that returns in the done cycle
  task automatic run_command(input string name, input gp_op_e op,
                             input logic [`PS_ADDR_W-1:0] addr,
                             input logic [`PS_DATA_W-1:0] wdata, output gp_resp_e resp,
                             output logic [`PS_DATA_W-1:0] rdata);
    @(posedge clk);
    cmd_valid_i <= 1'b1;
    cmd_op_i    <= op;
    cmd_addr_i  <= addr;
    cmd_wdata_i <= wdata;
    // new pin pattern with each write and steady across reads
    if (op == OP_WRITE) begin
      gpio_pat = `GPIO_W'($random(seed));
      gpio_i  <= gpio_pat;
    end
    @(posedge clk);
    cmd_valid_i <= 1'b0;
    // latency varies under stalls so done marks the end
    @(negedge clk);
    while (cmd_done_o !== 1'b1) begin
      // busy from the edge that took the command
      check_level({name, " cmd_busy_o"}, 1'b1, cmd_busy_o);
      @(negedge clk);
    end
    // busy already low in the done cycle
    check_level({name, " cmd_busy_o"}, 1'b0, cmd_busy_o);
    resp  = cmd_resp_o;
    rdata = cmd_rdata_o;
  endtask

  //////////////////////////////////////////////////////////////////////
  // timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      abort_run("run hung waiting for command done or for the SPI engine to go idle");
    end
  end

  // sck sampled between clock edges
  always @(negedge clk) begin
    sck_q <= spi_sck_o;
    if (spi_sck_o === 1'b1 && sck_q === 1'b0) begin
      sck_rises <= sck_rises + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    gp_resp_e              exp_resp;
    gp_resp_e              resp;
    logic [`PS_DATA_W-1:0] exp_data;
    logic [`PS_DATA_W-1:0] rdata;
    logic                  data_used;
    int                    cnt;
    int unsigned           sck_seen;
    arst_n_i    = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = OP_READ;
    cmd_addr_i  = '0;
    cmd_wdata_i = '0;
    gpio_pat    = `GPIO_W'($random(seed));
    gpio_i      = gpio_pat;
    exp_out     = '0;
    exp_dir     = '0;
    exp_data    = '0;
    sck_seen    = 0;
    load_cases();
    cycle_limit = case_name.size() * CASE_CYCLES;
    repeat (4) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    // all pins tristated and slave deselected
    check_gpio("reset gpio_t_o", '1, gpio_t_o);
    check_level("reset spi_ss_n_o", 1'b1, spi_ss_n_o);
    // command port and spi pins idle
    check_level("reset cmd_busy_o", 1'b0, cmd_busy_o);
    check_level("reset cmd_done_o", 1'b0, cmd_done_o);
    check_level("reset spi_sck_o", 1'b0, spi_sck_o);
    check_level("reset spi_mosi_o", 1'b0, spi_mosi_o);
    foreach (case_name[i]) begin
      if (case_resp[i] == "OKAY") begin
        exp_resp = RESP_OKAY;
      end else if (case_resp[i] == "SLVERR") begin
        exp_resp = RESP_SLVERR;
      end else begin
        abort_run({"unknown response token in case ", case_name[i]});
      end
      // data token is hex, X for the sampled pins or - for none
      data_used = 1'b1;
      if (case_data[i] == "-") begin
        data_used = 1'b0;
      end else if (case_data[i] == "X") begin
        exp_data = {{(`PS_DATA_W-`GPIO_W){1'b0}}, gpio_pat};
      end else begin
        cnt = $sscanf(case_data[i], "%h", exp_data);
        if (cnt != 1) begin
          abort_run({"unreadable expected data in case ", case_name[i]});
        end
      end
      if (case_op[i] == "W") begin
        run_command(case_name[i], OP_WRITE, case_addr[i], case_wdata[i], resp, rdata);
        check_resp(case_name[i], exp_resp, resp);
        if (case_addr[i] == `REG_GPIO_OUT) begin
          exp_out = case_wdata[i][`GPIO_W-1:0];
        end
        if (case_addr[i] == `REG_GPIO_DIR) begin
          exp_dir = case_wdata[i][`GPIO_W-1:0];
        end
      end else if (case_op[i] == "R") begin
        run_command(case_name[i], OP_READ, case_addr[i], '0, resp, rdata);
        check_resp(case_name[i], exp_resp, resp);
        if (data_used) begin
          check_data(case_name[i], exp_data, rdata);
        end
      end else if (case_op[i] == "P") begin
        // status polled until busy clears
        do begin
          run_command(case_name[i], OP_READ, case_addr[i], '0, resp, rdata);
          check_resp(case_name[i], exp_resp, resp);
        end while (rdata[0] !== 1'b0);
        check_data(case_name[i], exp_data, rdata);
        // one sck pulse per bit of the byte
        check_count({case_name[i], " sck rises"}, 8, sck_rises - sck_seen);
        sck_seen = sck_rises;
      end else begin
        abort_run({"unknown op letter in case ", case_name[i]});
      end
      check_gpio({case_name[i], " gpio_o"}, exp_out, gpio_o);
      check_gpio({case_name[i], " gpio_t_o"}, ~exp_dir, gpio_t_o);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_ps_system
